//--- hw/gameControl.sv
`timescale 1ns/10ps
`default_nettype none

module gameControl
(
	input  logic CLOCK_50,
	input  logic reset,
	input  logic [3:0] keyPress,
	pianoTilesIf.control game,
	output logic gameOver
);
	localparam logic [1:0] statePlaying = 2'd0;
	localparam logic [1:0] stateOver = 2'd1;
	localparam logic [1:0] stateRestart = 2'd2;

	logic [1:0] state;

	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			state <= statePlaying;
			gameOver <= 1'b0;
		end
		else
		begin
			case (state)
				statePlaying:
				begin
					if (game.miss)
					begin
						state <= stateOver;
						gameOver <= 1'b1;
					end
				end
				stateOver:
				begin
					// Any column key starts a new game
					if (|keyPress)
					begin
						state <= stateRestart;
						gameOver <= 1'b0;
					end
				end
				stateRestart:
					state <= statePlaying;
				default:
					state <= statePlaying;
			endcase
		end
	end

	assign game.run = (state == statePlaying);
	// Single-cycle wipe of slots, timers and score
	assign game.clear = (state == stateRestart);

endmodule

`default_nettype wire

//--- hw/pianoTiles.sv
`timescale 1ns/10ps
`default_nettype none

`include "pianoTiles_macros.svh"

module pianoTiles
#(
	parameter int unsigned stepPeriodInit = `STEP_PERIOD,
	parameter int unsigned spawnPeriodInit = `SPAWN_PERIOD,
	parameter int unsigned speedupPeriod = `SPEEDUP_PERIOD
)
(
	input  logic CLOCK_50,
	input  logic reset,
	input  logic [3:0] keyPress,
	output logic [6:0] score,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic gameOver
);
	pianoTilesIf game();

	// Playing, over and restart sequencing
	gameControl i_gameControl
	(
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.keyPress(keyPress),
		.game(game),
		.gameOver(gameOver)
	);

	tileTimer
	#(
		.stepPeriodInit(stepPeriodInit),
		.spawnPeriodInit(spawnPeriodInit),
		.speedupPeriod(speedupPeriod)
	) i_tileTimer
	(
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.game(game)
	);

	// Tiles, key judging and the random column source
	tileField i_tileField
	(
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.keyPress(keyPress),
		.game(game)
	);

	scoreDisplay i_scoreDisplay
	(
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.game(game),
		.score(score),
		.hex0(hex0),
		.hex1(hex1)
	);

endmodule

`default_nettype wire

//--- hw/pianoTilesIf.sv
`timescale 1ns/10ps
`default_nettype none

interface pianoTilesIf;
	// Game state from the control FSM
	logic run;
	logic clear;
	// Timing pulses
	logic stepTick;
	logic spawnTick;
	// Outcome of a key press or a passing tile
	logic hit;
	logic miss;

	modport control
	(
		output run,
		output clear,
		input  miss
	);

	modport timer
	(
		input  run,
		input  clear,
		output stepTick,
		output spawnTick
	);

	modport field
	(
		input  run,
		input  clear,
		input  stepTick,
		input  spawnTick,
		output hit,
		output miss
	);

	modport score
	(
		input hit,
		input clear
	);
endinterface

`default_nettype wire

//--- hw/pianoTilesPkg.sv
`default_nettype none

`include "pianoTiles_macros.svh"

package pianoTilesPkg;

	// Shift left with feedback taps at 23, 22, 17 and 16
	function automatic logic [23:0] lfsrStep(input logic [23:0] value);
		return {value[22:0], value[23] ^ value[22] ^ value[17] ^ value[16]};
	endfunction

	function automatic logic inHitZone(input logic [`ROW_BITS-1:0] row);
		return row > `ROW_BITS'(`HIT_ROW);
	endfunction

	// Period never drops under the floor
	function automatic logic [`PERIOD_BITS-1:0] shrinkPeriod(
		input logic [`PERIOD_BITS-1:0] period,
		input logic [`PERIOD_BITS-1:0] decrement,
		input logic [`PERIOD_BITS-1:0] floorValue);
		if (period >= floorValue + decrement)
			return period - decrement;
		return period;
	endfunction

	// Active-low segments in gfedcba order
	function automatic logic [6:0] segmentOf(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- hw/pianoTiles_macros.svh
`ifndef PIANO_TILES_MACROS_SVH
`define PIANO_TILES_MACROS_SVH

// Screen geometry in rows
`define ROW_COUNT 120
`define TILE_HEIGHT 30
`define ROW_BITS 7
// A tile top below this row is inside the hit zone
`define HIT_ROW (`ROW_COUNT - `TILE_HEIGHT)

`define COLUMN_COUNT 4
`define SLOT_COUNT 4

`define LFSR_SEED 24'h800001

// Board periods in clock cycles at 50 MHz
`define PERIOD_BITS 26
`define STEP_PERIOD 416666
`define SPAWN_PERIOD 50000000
`define SPEEDUP_PERIOD 50000000

// Speed-up steps and the floors they stop at
`define STEP_DECREMENT 2000
`define STEP_MIN 226333
`define SPAWN_DECREMENT 750000
`define SPAWN_MIN 12500000

`define SCORE_MAX 99

`endif

//--- hw/scoreDisplay.sv
`timescale 1ns/10ps
`default_nettype none

`include "pianoTiles_macros.svh"

module scoreDisplay
(
	input  logic CLOCK_50,
	input  logic reset,
	pianoTilesIf.score game,
	output logic [6:0] score,
	output logic [6:0] hex0,
	output logic [6:0] hex1
);
	import pianoTilesPkg::*;

	localparam logic [6:0] scoreMax = 7'(`SCORE_MAX);

	logic [3:0] tens;
	logic [3:0] ones;

	always_ff @(posedge CLOCK_50)
	begin
		if (reset || game.clear)
			score <= '0;
		// Holds at the top of the two-digit range
		else if (game.hit && score != scoreMax)
			score <= score + 1'b1;
	end

	// Decimal split for the two displays
	assign tens = 4'(score / 7'd10);
	assign ones = 4'(score % 7'd10);

	assign hex0 = segmentOf(ones);
	assign hex1 = segmentOf(tens);

endmodule

`default_nettype wire

//--- hw/tileField.sv
`timescale 1ns/10ps
`default_nettype none

`include "pianoTiles_macros.svh"

module tileField
(
	input  logic CLOCK_50,
	input  logic reset,
	input  logic [3:0] keyPress,
	pianoTilesIf.field game
);
	import pianoTilesPkg::*;

	localparam logic [`ROW_BITS-1:0] lastRow = `ROW_BITS'(`ROW_COUNT - 1);

	logic [23:0] lfsr;

	// Slot state
	logic [`SLOT_COUNT-1:0] slotActive;
	logic [`SLOT_COUNT-1:0] slotScored;
	logic [1:0] slotColumn [`SLOT_COUNT];
	logic [`ROW_BITS-1:0] slotRow [`SLOT_COUNT];

	logic [`SLOT_COUNT-1:0] activeNext;
	logic [`SLOT_COUNT-1:0] scoredNext;
	logic [1:0] columnNext [`SLOT_COUNT];
	logic [`ROW_BITS-1:0] rowNext [`SLOT_COUNT];
	logic hitNext;
	logic missNext;
	logic slotFound;
	logic spawnDone;
	logic hitPulse;
	logic missPulse;

	always_comb
	begin
		activeNext = slotActive;
		scoredNext = slotScored;
		columnNext = slotColumn;
		rowNext = slotRow;
		hitNext = 1'b0;
		missNext = 1'b0;
		slotFound = 1'b0;
		spawnDone = 1'b0;
		if (game.run)
		begin
			// Key judging against the registered slots
			for (int c = 0; c < `COLUMN_COUNT; c++)
			begin
				slotFound = 1'b0;
				if (keyPress[c])
				begin
					for (int s = 0; s < `SLOT_COUNT; s++)
					begin
						if (!slotFound && slotActive[s] && slotColumn[s] == 2'(c)
							&& inHitZone(slotRow[s]))
						begin
							slotFound = 1'b1;
							if (!slotScored[s])
							begin
								scoredNext[s] = 1'b1;
								hitNext = 1'b1;
							end
						end
					end
					if (!slotFound)
						missNext = 1'b1;
				end
			end
			// Falling, and tiles leaving the bottom
			if (game.stepTick)
			begin
				for (int s = 0; s < `SLOT_COUNT; s++)
				begin
					if (slotActive[s])
					begin
						if (slotRow[s] < lastRow)
							rowNext[s] = slotRow[s] + 1'b1;
						else
						begin
							activeNext[s] = 1'b0;
							// A tile scored in this very cycle is not lost
							if (!scoredNext[s])
								missNext = 1'b1;
						end
					end
				end
			end
			// Lowest free slot takes the new tile
			if (game.spawnTick)
			begin
				for (int s = 0; s < `SLOT_COUNT; s++)
				begin
					if (!spawnDone && !slotActive[s])
					begin
						spawnDone = 1'b1;
						activeNext[s] = 1'b1;
						scoredNext[s] = 1'b0;
						columnNext[s] = lfsr[1:0];
						rowNext[s] = '0;
					end
				end
			end
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			lfsr <= `LFSR_SEED;
			slotActive <= '0;
			slotScored <= '0;
			hitPulse <= 1'b0;
			missPulse <= 1'b0;
		end
		else
		begin
			lfsr <= lfsrStep(lfsr);
			slotActive <= game.clear ? '0 : activeNext;
			slotScored <= game.clear ? '0 : scoredNext;
			hitPulse <= hitNext;
			missPulse <= missNext;
		end
	end

	// Column and top row of each slot
	always_ff @(posedge CLOCK_50)
	begin
		slotColumn <= columnNext;
		slotRow <= rowNext;
	end

	assign game.hit = hitPulse;
	assign game.miss = missPulse;

endmodule

`default_nettype wire

//--- hw/tileTimer.sv
`timescale 1ns/10ps
`default_nettype none

`include "pianoTiles_macros.svh"

module tileTimer
#(
	parameter int unsigned stepPeriodInit = `STEP_PERIOD,
	parameter int unsigned spawnPeriodInit = `SPAWN_PERIOD,
	parameter int unsigned speedupPeriod = `SPEEDUP_PERIOD
)
(
	input  logic CLOCK_50,
	input  logic reset,
	pianoTilesIf.timer game
);
	import pianoTilesPkg::*;

	localparam int periodBits = `PERIOD_BITS;
	localparam logic [periodBits-1:0] stepInit = periodBits'(stepPeriodInit);
	localparam logic [periodBits-1:0] spawnInit = periodBits'(spawnPeriodInit);
	localparam logic [periodBits-1:0] speedupLast = periodBits'(speedupPeriod - 1);

	logic [periodBits-1:0] stepCount;
	logic [periodBits-1:0] spawnCount;
	logic [periodBits-1:0] speedCount;
	logic [periodBits-1:0] stepPeriod;
	logic [periodBits-1:0] spawnPeriod;
	logic stepWrap;
	logic spawnWrap;
	logic speedWrap;

	// Each counter wraps on the last cycle of its current period
	assign stepWrap = game.run && (stepCount == stepPeriod - 1'b1);
	assign spawnWrap = game.run && (spawnCount == spawnPeriod - 1'b1);
	assign speedWrap = game.run && (speedCount == speedupLast);

	always_ff @(posedge CLOCK_50)
	begin
		if (reset || game.clear)
		begin
			stepCount <= '0;
			spawnCount <= '0;
			speedCount <= '0;
			stepPeriod <= stepInit;
			spawnPeriod <= spawnInit;
		end
		else if (game.run)
		begin
			stepCount <= stepWrap ? '0 : stepCount + 1'b1;
			spawnCount <= spawnWrap ? '0 : spawnCount + 1'b1;
			speedCount <= speedWrap ? '0 : speedCount + 1'b1;
			// Game gets faster at every speed-up wrap
			if (speedWrap)
			begin
				stepPeriod <= shrinkPeriod(stepPeriod, periodBits'(`STEP_DECREMENT),
					periodBits'(`STEP_MIN));
				spawnPeriod <= shrinkPeriod(spawnPeriod, periodBits'(`SPAWN_DECREMENT),
					periodBits'(`SPAWN_MIN));
			end
		end
	end

	assign game.stepTick = stepWrap;
	assign game.spawnTick = spawnWrap;

endmodule

`default_nettype wire

//--- pianoTiles.f
+incdir+hw
hw/pianoTilesPkg.sv
hw/pianoTilesIf.sv
hw/gameControl.sv
hw/tileTimer.sv
hw/tileField.sv
hw/scoreDisplay.sv
hw/pianoTiles.sv
tb/tb_pianoTiles.sv

//--- tb/tb_pianoTiles.sv
`timescale 1ns/10ps
`default_nettype none

`include "pianoTiles_macros.svh"

module tb_pianoTiles;

	localparam int stepPeriod = 4;
	localparam int spawnPeriod = 150;
	localparam int speedupPeriod = 600;
	localparam int hitRow = `ROW_COUNT - `TILE_HEIGHT;
	localparam int statePlaying = 0;
	localparam int stateOver = 1;
	localparam int stateRestart = 2;

	// Test lengths in cycles
	localparam int hitCycles = 2000;
	localparam int holdCycles = 50;
	localparam int playCycles = 1500;
	localparam int waitLimit = 1000;
	localparam int speedCycles = 4000;
	localparam int testCycles = 3 + hitCycles + 12 + holdCycles + 14 + playCycles
		+ 14 + waitLimit + 14 + speedCycles;
	localparam int cycleLimit = testCycles + 1000;

	logic CLOCK_50;
	logic reset;
	logic [3:0] keyPress;
	logic [6:0] score;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic gameOver;

	integer seed = 32'h086a_15ed;
	int cycleCount = 0;
	int errorCount = 0;
	int testCount = 0;
	int failedTests = 0;
	int errorsBefore;
	int waited;
	bit checking = 1'b0;
	int keyMode = 0;
	bit wrongRequest = 1'b0;
	bit anyRequest = 1'b0;
	logic [3:0] nextKey;
	logic [6:0] heldScore;

	// Model of the game state
	logic [23:0] mLfsr;
	int mStepCount;
	int mSpawnCount;
	int mSpeedCount;
	int mStepPeriod;
	int mSpawnPeriod;
	bit mActive [`SLOT_COUNT];
	bit mScored [`SLOT_COUNT];
	int mColumn [`SLOT_COUNT];
	int mRow [`SLOT_COUNT];
	bit mHit;
	bit mMiss;
	int mState;
	bit mGameOver;
	int mScore;

	pianoTiles
	#(
		.stepPeriodInit(stepPeriod),
		.spawnPeriodInit(spawnPeriod),
		.speedupPeriod(speedupPeriod)
	) i_dut
	(
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.keyPress(keyPress),
		.score(score),
		.hex0(hex0),
		.hex1(hex1),
		.gameOver(gameOver)
	);

	always #2 CLOCK_50 = ~CLOCK_50;

	function automatic logic [6:0] expectedSegment(input int digit);
		case (digit)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	function automatic bit columnHasZoneTile(input int c);
		for (int s = 0; s < `SLOT_COUNT; s++)
			if (mActive[s] && mColumn[s] == c && mRow[s] > hitRow)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic checkScore(input logic [6:0] actual, input logic [6:0] expected);
		if (actual !== expected)
		begin
			$display("** Error at %0t: score is %0d, expected %0d", $time, actual, expected);
			errorCount++;
		end
	endtask

	task automatic checkSegments(input logic [6:0] actual, input logic [6:0] expected,
		input string digitName);
		if (actual !== expected)
		begin
			$display("** Error at %0t: %s shows %b, expected %b", $time, digitName, actual,
				expected);
			errorCount++;
		end
	endtask

	task automatic checkGameOver(input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("** Error at %0t: gameOver is %b, expected %b", $time, actual, expected);
			errorCount++;
		end
	endtask

	task automatic resetModel();
		mLfsr = `LFSR_SEED;
		mStepCount = 0;
		mSpawnCount = 0;
		mSpeedCount = 0;
		mStepPeriod = stepPeriod;
		mSpawnPeriod = spawnPeriod;
		for (int s = 0; s < `SLOT_COUNT; s++)
		begin
			mActive[s] = 1'b0;
			mScored[s] = 1'b0;
		end
		mHit = 1'b0;
		mMiss = 1'b0;
		mState = statePlaying;
		mGameOver = 1'b0;
		mScore = 0;
	endtask

	// Advances the whole game by one clock edge
	task automatic advanceModel(input logic [3:0] key);
		bit run;
		bit clear;
		bit stepTick;
		bit spawnTick;
		bit speedTick;
		bit found;
		bit spawned;
		bit hitNext;
		bit missNext;
		bit activeNext [`SLOT_COUNT];
		bit scoredNext [`SLOT_COUNT];
		int columnNext [`SLOT_COUNT];
		int rowNext [`SLOT_COUNT];
		run = (mState == statePlaying);
		clear = (mState == stateRestart);
		stepTick = run && (mStepCount == mStepPeriod - 1);
		spawnTick = run && (mSpawnCount == mSpawnPeriod - 1);
		speedTick = run && (mSpeedCount == speedupPeriod - 1);
		hitNext = 1'b0;
		missNext = 1'b0;
		spawned = 1'b0;
		for (int s = 0; s < `SLOT_COUNT; s++)
		begin
			activeNext[s] = mActive[s];
			scoredNext[s] = mScored[s];
			columnNext[s] = mColumn[s];
			rowNext[s] = mRow[s];
		end
		if (run)
		begin
			for (int c = 0; c < `COLUMN_COUNT; c++)
				if (key[c])
				begin
					found = 1'b0;
					for (int s = 0; s < `SLOT_COUNT; s++)
						if (!found && mActive[s] && mColumn[s] == c && mRow[s] > hitRow)
						begin
							found = 1'b1;
							if (!mScored[s])
							begin
								scoredNext[s] = 1'b1;
								hitNext = 1'b1;
							end
						end
					if (!found)
						missNext = 1'b1;
				end
			if (stepTick)
				for (int s = 0; s < `SLOT_COUNT; s++)
					if (mActive[s] && mRow[s] < `ROW_COUNT - 1)
						rowNext[s] = mRow[s] + 1;
					else if (mActive[s])
					begin
						activeNext[s] = 1'b0;
						// Scored by a key in this same cycle counts as caught
						if (!scoredNext[s])
							missNext = 1'b1;
					end
			if (spawnTick)
				for (int s = 0; s < `SLOT_COUNT; s++)
					if (!spawned && !mActive[s])
					begin
						spawned = 1'b1;
						activeNext[s] = 1'b1;
						scoredNext[s] = 1'b0;
						columnNext[s] = mLfsr[1:0];
						rowNext[s] = 0;
					end
		end
		if (mState == statePlaying && mMiss)
		begin
			mState = stateOver;
			mGameOver = 1'b1;
		end
		else if (mState == stateOver && key != 4'b0)
		begin
			mState = stateRestart;
			mGameOver = 1'b0;
		end
		else if (mState == stateRestart)
			mState = statePlaying;
		if (clear)
			mScore = 0;
		else if (mHit && mScore < `SCORE_MAX)
			mScore++;
		if (clear)
		begin
			mStepCount = 0;
			mSpawnCount = 0;
			mSpeedCount = 0;
			mStepPeriod = stepPeriod;
			mSpawnPeriod = spawnPeriod;
		end
		else if (run)
		begin
			mStepCount = stepTick ? 0 : mStepCount + 1;
			mSpawnCount = spawnTick ? 0 : mSpawnCount + 1;
			mSpeedCount = speedTick ? 0 : mSpeedCount + 1;
			if (speedTick && mStepPeriod >= `STEP_MIN + `STEP_DECREMENT)
				mStepPeriod -= `STEP_DECREMENT;
			if (speedTick && mSpawnPeriod >= `SPAWN_MIN + `SPAWN_DECREMENT)
				mSpawnPeriod -= `SPAWN_DECREMENT;
		end
		for (int s = 0; s < `SLOT_COUNT; s++)
		begin
			mActive[s] = clear ? 1'b0 : activeNext[s];
			mScored[s] = clear ? 1'b0 : scoredNext[s];
			mColumn[s] = columnNext[s];
			mRow[s] = rowNext[s];
		end
		mLfsr = {mLfsr[22:0], mLfsr[23] ^ mLfsr[22] ^ mLfsr[17] ^ mLfsr[16]};
		mHit = hitNext;
		mMiss = missNext;
	endtask

	// Picks the key for the coming cycle from the model state after this edge
	task automatic chooseKey(output logic [3:0] key);
		logic [31:0] r;
		int zoneSlots [`SLOT_COUNT];
		int count;
		int c;
		key = 4'b0;
		r = $random(seed);
		count = 0;
		for (int s = 0; s < `SLOT_COUNT; s++)
			if (mActive[s] && mRow[s] > hitRow)
			begin
				zoneSlots[count] = s;
				count++;
			end
		if (anyRequest && mState == stateOver)
		begin
			key[r[1:0]] = 1'b1;
			anyRequest = 1'b0;
		end
		else if (wrongRequest && mState == statePlaying)
		begin
			c = r[1:0];
			for (int t = 0; t < `COLUMN_COUNT; t++)
				if (columnHasZoneTile(c))
					c = (c + 1) % `COLUMN_COUNT;
			key[c] = 1'b1;
			wrongRequest = 1'b0;
		end
		else if (mState == statePlaying && keyMode == 2 && r[15:8] == 8'd0)
			key[r[17:16]] = 1'b1;
		else if (mState == statePlaying && keyMode != 0 && count > 0 && r[4:2] != 3'd0)
			key[mColumn[zoneSlots[r[9:8] % count]]] = 1'b1;
	endtask

	task automatic waitForGameOver(input logic level, input int limit, output int cycles);
		cycles = 0;
		while (gameOver !== level && cycles < limit)
		begin
			@(negedge CLOCK_50);
			cycles++;
		end
		if (gameOver !== level)
		begin
			$display("gameOver did not go to %0b within %0d cycles", level, limit);
			errorCount++;
		end
	endtask

	task automatic restartGame();
		int cycles;
		anyRequest = 1'b1;
		while (anyRequest)
			@(negedge CLOCK_50);
		waitForGameOver(1'b0, 2, cycles);
		@(negedge CLOCK_50);
		checkScore(score, 7'd0);
	endtask

	task automatic reportTest(input string name, input int errorsAtStart);
		testCount++;
		if (errorCount == errorsAtStart)
			$display("Test %s: passed", name);
		else
		begin
			failedTests++;
			$display("Test %s: FAILED with %0d errors", name, errorCount - errorsAtStart);
		end
	endtask

	always @(posedge CLOCK_50)
	begin
		if (reset)
			resetModel();
		else
			advanceModel(keyPress);
		chooseKey(nextKey);
		keyPress <= nextKey;
	end

	// Outputs are settled by the falling edge
	always @(negedge CLOCK_50)
	begin
		if (checking)
		begin
			checkScore(score, 7'(mScore));
			checkSegments(hex0, expectedSegment(mScore % 10), "hex0");
			checkSegments(hex1, expectedSegment(mScore / 10), "hex1");
			checkGameOver(gameOver, mGameOver);
		end
	end

	always @(posedge CLOCK_50)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout: the run went past %0d cycles", cycleLimit);
			$display("Something failed");
			$finish;
		end
	end

	initial
	begin
		CLOCK_50 = 1'b0;
		reset = 1'b1;
		keyPress = 4'b0;
		repeat (2) @(posedge CLOCK_50);
		reset <= 1'b0;
		@(negedge CLOCK_50);
		checking = 1'b1;

		errorsBefore = errorCount;
		checkGameOver(gameOver, 1'b0);
		checkScore(score, 7'd0);
		checkSegments(hex0, expectedSegment(0), "hex0");
		checkSegments(hex1, expectedSegment(0), "hex1");
		reportTest("reset", errorsBefore);

		errorsBefore = errorCount;
		keyMode = 1;
		repeat (hitCycles) @(negedge CLOCK_50);
		if (score == 7'd0)
		begin
			$display("No tile was scored during the hit run");
			errorCount++;
		end
		reportTest("hits", errorsBefore);

		// One press on a column with nothing in its hit zone
		errorsBefore = errorCount;
		keyMode = 0;
		wrongRequest = 1'b1;
		while (wrongRequest)
			@(negedge CLOCK_50);
		waitForGameOver(1'b1, 10, waited);
		if (waited != 2)
		begin
			$display("gameOver rose %0d cycles after the wrong press instead of 2", waited);
			errorCount++;
		end
		heldScore = 7'(mScore);
		repeat (holdCycles) @(negedge CLOCK_50);
		checkScore(score, heldScore);
		reportTest("wrong press", errorsBefore);

		errorsBefore = errorCount;
		restartGame();
		keyMode = 2;
		repeat (playCycles) @(negedge CLOCK_50);
		keyMode = 0;
		reportTest("restart", errorsBefore);

		// A fresh game without presses ends when the first tile falls through
		errorsBefore = errorCount;
		if (gameOver)
			restartGame();
		waitForGameOver(1'b1, waitLimit, waited);
		$display("Passing tile ended the game after %0d cycles", waited);
		reportTest("passing tile", errorsBefore);

		errorsBefore = errorCount;
		restartGame();
		keyMode = 1;
		repeat (speedCycles) @(negedge CLOCK_50);
		keyMode = 0;
		if (gameOver)
		begin
			$display("The game ended during the run of correct presses");
			errorCount++;
		end
		reportTest("speed-up", errorsBefore);

		$display("Tests run %0d, tests failed %0d, errors %0d", testCount, failedTests,
			errorCount);
		if (errorCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
